// ==== Makefile ====
LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f src.f --top-module controlUnit
	verilator --lint-only --timing -f src.f --top-module controlUnitTb

sim:
	verilator --binary --timing -f src.f --top-module controlUnitTb -o controlUnitTbSim
	./obj_dir/controlUnitTbSim > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG) || ! grep -q "Simulation completed successfully" $(LOG); then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// ==== src.f ====
src/isaPkg.sv
src/ctrlPkg.sv
src/controlDecoder.sv
src/branchUnit.sv
src/hazardUnit.sv
src/controlPipeline.sv
src/controlUnit.sv
verif/controlUnitTb.sv

// ==== src/branchUnit.sv ====
`timescale 1ns/1ns

module branchUnit (
    input  logic            branchE,
    input  isaPkg::funct3_t funct3E,
    input  logic            Z,                          // ALU result was zero
    input  logic            N,                          // ALU result was negative
    output logic            conditionMetE
);
    import isaPkg::*;

    // Flags come from the sub that the decoder forces on branches
    always_comb begin
        conditionMetE = 1'b0;
        if (branchE) begin
            case (funct3E)
                Beq:     conditionMetE = Z;
                Bne:     conditionMetE = ~Z;
                Blt:     conditionMetE = N;             // Signed less than
                Bge:     conditionMetE = ~N;
                default: conditionMetE = 1'b0;          // Unsigned forms not supported
            endcase
        end
    end

endmodule

// ==== src/controlDecoder.sv ====
`timescale 1ns/1ns

module controlDecoder (
    input  ctrlPkg::fetchFields_t fieldsD,
    output ctrlPkg::decodeCtrl_t  ctrlD,
    output logic                  branchD,
    output logic                  jumpD,
    output ctrlPkg::immFormat_t   ImmFormatD
);
    import isaPkg::*;
    import ctrlPkg::*;

    // Shared ALU mapping for R-type and I-type
    function automatic aluFunc_t aluFuncOf(input funct3_t f3, input logic subtract);
        case (f3)
            F3AddSub: return subtract ? AluSub : AluAdd;
            F3And:    return AluAnd;
            F3Or:     return AluOr;
            F3Xor:    return AluXor;
            F3Slt:    return AluSlt;
            F3Sll:    return AluSll;
            F3Srl:    return AluSrl;
            default:  return AluAdd;                    // sltu slot falls back to add
        endcase
    endfunction

    always_comb begin
        ctrlD      = '0;                                // Unknown opcode is a bubble
        ImmFormatD = ImmI;
        case (fieldsD.opcode)
            OpRType: begin
                ctrlD.regWeExec = 1'b1;
                ctrlD.exPath    = PathAlu;
                ctrlD.aluFunc   = aluFuncOf(fieldsD.funct3, fieldsD.funct7b5);
            end
            OpIType: begin
                ctrlD.regWeExec = 1'b1;
                ctrlD.opBSrc    = 1'b1;
                ctrlD.exPath    = PathAlu;
                ctrlD.aluFunc   = aluFuncOf(fieldsD.funct3, 1'b0);  // No subi
            end
            OpLoad: begin
                ctrlD.regWeMem = 1'b1;                  // Result comes back via memory
                ctrlD.opBSrc   = 1'b1;
                ctrlD.exPath   = PathAddr;
                ctrlD.aluFunc  = AluAdd;
            end
            OpStore: begin
                ctrlD.memWrite = 1'b1;
                ctrlD.opBSrc   = 1'b1;
                ctrlD.aluFunc  = AluAdd;                // Base plus offset
                ImmFormatD     = ImmS;
            end
            OpBranch: begin
                ctrlD.branch  = 1'b1;
                ctrlD.aluFunc = AluSub;                 // Sets Z and N for the compare
                ctrlD.funct3  = fieldsD.funct3;         // Condition travels to Execute
                ImmFormatD    = ImmB;
            end
            OpJal: begin
                ctrlD.jump      = 1'b1;
                ctrlD.regWeExec = 1'b1;
                ctrlD.exPath    = PathLink;
                ImmFormatD      = ImmJ;
            end
            OpBnn: begin
                case (fieldsD.funct3)
                    BnnRun: begin
                        ctrlD.regWeExec = 1'b1;
                        ctrlD.exPath    = PathBnn;
                    end
                    BnnSetSize:   ctrlD.msWe = 1'b1;    // Configuration write only
                    BnnSetThresh: ctrlD.atWe = 1'b1;
                    BnnRunThresh: begin
                        ctrlD.regWeExec   = 1'b1;
                        ctrlD.exPath      = PathBnn;
                        ctrlD.enThreshold = 1'b1;
                    end
                    default: ;                          // Reserved BNN codes do nothing
                endcase
            end
            default: ;
        endcase
    end

    assign branchD = ctrlD.branch;
    assign jumpD   = ctrlD.jump;

endmodule

// ==== src/controlPipeline.sv ====
`timescale 1ns/1ns

module controlPipeline (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  StallD,
    input  logic                  FlushD,
    input  logic                  StallE,
    input  logic                  FlushE,
    input  logic                  FlushW,
    input  ctrlPkg::fetchFields_t fieldsF,
    input  ctrlPkg::decodeCtrl_t  ctrlD,
    output ctrlPkg::fetchFields_t fieldsD,
    output ctrlPkg::decodeCtrl_t  ctrlE,
    output ctrlPkg::wbCtrl_t      ctrlW
);

    // Fetch to Decode register
    // Only the fields the decoder looks at are kept
    always_ff @(posedge clk) begin
        if (reset || FlushD) begin
            fieldsD <= '0;                              // Zero opcode decodes as bubble
        end else if (!StallD) begin
            fieldsD <= fieldsF;
        end
    end

    // Decode to Execute register
    always_ff @(posedge clk) begin
        if (reset || FlushE) begin
            ctrlE <= '0;                                // Flush beats stall
        end else if (!StallE) begin
            ctrlE <= ctrlD;
        end
    end

    // Execute to Writeback register
    always_ff @(posedge clk) begin
        if (reset || FlushW) begin
            ctrlW <= '0;
        end else begin                                  // Never held
            ctrlW <= '{
                regWeExec: ctrlE.regWeExec,
                regWeMem:  ctrlE.regWeMem,
                memWrite:  ctrlE.memWrite
            };
        end
    end

endmodule

// ==== src/controlUnit.sv ====
`timescale 1ns/1ns

module controlUnit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 Z,
    input  logic                 N,
    input  logic                 RegWE_W_W2,            // From the load stall buffer
    input  isaPkg::regAddr_t     A1_E,
    input  isaPkg::regAddr_t     A2_E,
    input  isaPkg::regAddr_t     A3_W,
    input  isaPkg::regAddr_t     A4_W2,
    input  isaPkg::instr_t       InstrF,
    output logic                 RegWE_E_E,             // Execute result write
    output logic                 RegWE_W_W,             // Load data write in W
    output logic                 OpBSrcE,
    output logic                 en_threshold_E,
    output logic                 ms_WE_E,
    output logic                 at_WE_E,
    output logic                 StallF,
    output logic                 StallD,
    output logic                 FlushD,
    output logic                 StallE,
    output logic                 FlushE,
    output logic                 FlushW,
    output ctrlPkg::fwdSel_t     fwdA_E,
    output ctrlPkg::fwdSel_t     fwdB_E,
    output ctrlPkg::pcSrc_t      PCSrcE,
    output ctrlPkg::exPath_t     ExPathE,
    output ctrlPkg::immFormat_t  ImmFormatD,
    output ctrlPkg::aluFunc_t    ALUFuncE,
    output logic                 MemWriteW              // To data memory
);
    import ctrlPkg::*;

    fetchFields_t fieldsF;
    fetchFields_t fieldsD;
    decodeCtrl_t  ctrlD;
    decodeCtrl_t  ctrlE;
    wbCtrl_t      ctrlW;
    logic         conditionMetE;

    assign fieldsF = '{funct7b5: InstrF[30], funct3: InstrF[14:12], opcode: InstrF[6:0]};

    controlPipeline controlPipeline_inst (
        .clk     (clk),
        .reset   (reset),
        .StallD  (StallD),
        .FlushD  (FlushD),
        .StallE  (StallE),
        .FlushE  (FlushE),
        .FlushW  (FlushW),
        .fieldsF (fieldsF),
        .ctrlD   (ctrlD),
        .fieldsD (fieldsD),
        .ctrlE   (ctrlE),
        .ctrlW   (ctrlW)
    );

    controlDecoder controlDecoder_inst (
        .fieldsD    (fieldsD),
        .ctrlD      (ctrlD),
        .branchD    (),                                 // Only the registered copies matter
        .jumpD      (),
        .ImmFormatD (ImmFormatD)
    );

    branchUnit branchUnit_inst (
        .branchE       (ctrlE.branch),
        .funct3E       (ctrlE.funct3),
        .Z             (Z),
        .N             (N),
        .conditionMetE (conditionMetE)
    );

    hazardUnit hazardUnit_inst (
        .A1_E          (A1_E),
        .A2_E          (A2_E),
        .A3_W          (A3_W),
        .A4_W2         (A4_W2),
        .ctrlW         (ctrlW),
        .RegWE_W_W2    (RegWE_W_W2),
        .jumpE         (ctrlE.jump),
        .conditionMetE (conditionMetE),
        .StallF        (StallF),
        .StallD        (StallD),
        .StallE        (StallE),
        .FlushD        (FlushD),
        .FlushE        (FlushE),
        .FlushW        (FlushW),
        .PCSrcE        (PCSrcE),
        .fwdA_E        (fwdA_E),
        .fwdB_E        (fwdB_E)
    );

    // Execute stage controls
    assign RegWE_E_E      = ctrlE.regWeExec;
    assign OpBSrcE        = ctrlE.opBSrc;
    assign en_threshold_E = ctrlE.enThreshold;
    assign ms_WE_E        = ctrlE.msWe;
    assign at_WE_E        = ctrlE.atWe;
    assign ExPathE        = ctrlE.exPath;
    assign ALUFuncE       = ctrlE.aluFunc;

    // Writeback stage controls
    assign RegWE_W_W = ctrlW.regWeMem;
    assign MemWriteW = ctrlW.memWrite;

endmodule

// ==== src/ctrlPkg.sv ====
package ctrlPkg;

    typedef logic [2:0] aluFunc_t;                      // ALU operation select
    localparam aluFunc_t AluAdd = 3'b000;
    localparam aluFunc_t AluSub = 3'b001;
    localparam aluFunc_t AluAnd = 3'b010;
    localparam aluFunc_t AluOr  = 3'b011;
    localparam aluFunc_t AluXor = 3'b100;
    localparam aluFunc_t AluSlt = 3'b101;
    localparam aluFunc_t AluSll = 3'b110;
    localparam aluFunc_t AluSrl = 3'b111;

    typedef logic [1:0] exPath_t;                       // Execute result mux select
    localparam exPath_t PathAlu  = 2'b00;
    localparam exPath_t PathBnn  = 2'b01;
    localparam exPath_t PathLink = 2'b10;               // pc+4 for jal
    localparam exPath_t PathAddr = 2'b11;               // Load address to memory

    typedef logic [1:0] immFormat_t;                    // Extend unit format
    localparam immFormat_t ImmI = 2'b00;
    localparam immFormat_t ImmS = 2'b01;
    localparam immFormat_t ImmB = 2'b10;
    localparam immFormat_t ImmJ = 2'b11;

    typedef logic [1:0] fwdSel_t;                       // Operand bypass select
    localparam fwdSel_t FwdRf = 2'b00;
    localparam fwdSel_t FwdW2 = 2'b01;
    localparam fwdSel_t FwdW  = 2'b10;

    typedef logic [1:0] pcSrc_t;                        // Next PC select
    localparam pcSrc_t PcPlus4  = 2'b00;
    localparam pcSrc_t PcTarget = 2'b01;

    typedef struct packed {
        logic            funct7b5;                      // Instr bit 30
        isaPkg::funct3_t funct3;
        isaPkg::opcode_t opcode;
    } fetchFields_t;

    typedef struct packed {
        logic            regWeExec;                     // Writes an Execute result
        logic            regWeMem;                      // Writes loaded data
        logic            opBSrc;                        // Operand B is the immediate
        logic            memWrite;
        logic            enThreshold;
        logic            msWe;
        logic            atWe;
        logic            branch;
        logic            jump;
        exPath_t         exPath;
        aluFunc_t        aluFunc;
        isaPkg::funct3_t funct3;                        // Branch condition code
    } decodeCtrl_t;

    typedef struct packed {
        logic regWeExec;
        logic regWeMem;
        logic memWrite;
    } wbCtrl_t;

endpackage

// ==== src/hazardUnit.sv ====
`timescale 1ns/1ns

module hazardUnit (
    input  isaPkg::regAddr_t  A1_E,                     // Execute source 1
    input  isaPkg::regAddr_t  A2_E,                     // Execute source 2
    input  isaPkg::regAddr_t  A3_W,                     // Writeback destination
    input  isaPkg::regAddr_t  A4_W2,                    // Stall buffer destination
    input  ctrlPkg::wbCtrl_t  ctrlW,
    input  logic              RegWE_W_W2,               // From the load stall buffer
    input  logic              jumpE,
    input  logic              conditionMetE,
    output logic              StallF,
    output logic              StallD,
    output logic              StallE,
    output logic              FlushD,
    output logic              FlushE,
    output logic              FlushW,
    output ctrlPkg::pcSrc_t   PCSrcE,
    output ctrlPkg::fwdSel_t  fwdA_E,
    output ctrlPkg::fwdSel_t  fwdB_E
);
    import isaPkg::*;
    import ctrlPkg::*;

    logic loadUse;                                      // Load in W feeds an E operand
    logic redirect;                                     // Taken branch or jal in E

    // W has priority since it holds the younger result
    function automatic fwdSel_t selectFwd(
        input regAddr_t src,
        input logic     wWe,
        input regAddr_t wDst,
        input logic     w2We,
        input regAddr_t w2Dst
    );
        if (src == RegZero)
            return FwdRf;                               // x0 is never bypassed
        if (wWe && (wDst == src))
            return FwdW;
        if (w2We && (w2Dst == src))
            return FwdW2;
        return FwdRf;
    endfunction

    assign loadUse = ctrlW.regWeMem && (A3_W != RegZero)
                     && ((A3_W == A1_E) || (A3_W == A2_E));

    assign StallF = loadUse;                            // Freeze front end until data lands
    assign StallD = loadUse;
    assign StallE = loadUse;
    assign FlushW = loadUse;                            // Bubble into W behind the held E

    assign redirect = (jumpE || conditionMetE) && !loadUse;  // Held E must not redirect twice
    assign PCSrcE   = redirect ? PcTarget : PcPlus4;
    assign FlushD   = redirect;                         // Kill the two wrong-path slots
    assign FlushE   = redirect;

    assign fwdA_E = selectFwd(A1_E, ctrlW.regWeExec, A3_W, RegWE_W_W2, A4_W2);
    assign fwdB_E = selectFwd(A2_E, ctrlW.regWeExec, A3_W, RegWE_W_W2, A4_W2);

endmodule

// ==== src/isaPkg.sv ====
package isaPkg;

    typedef logic [31:0] instr_t;                       // Raw instruction word
    typedef logic [6:0]  opcode_t;                      // Major opcode in bits 6..0
    typedef logic [2:0]  funct3_t;                      // Minor function in bits 14..12
    typedef logic [4:0]  regAddr_t;                     // Register file index

    localparam regAddr_t RegZero = 5'd0;                // Hardwired zero register

    // Major opcodes
    localparam opcode_t OpRType  = 7'b0110011;          // Register-register ALU
    localparam opcode_t OpIType  = 7'b0010011;          // Register-immediate ALU
    localparam opcode_t OpLoad   = 7'b0000011;          // Word load
    localparam opcode_t OpStore  = 7'b0100011;          // Word store
    localparam opcode_t OpBranch = 7'b1100011;          // Conditional branch
    localparam opcode_t OpJal    = 7'b1101111;          // Jump and link
    localparam opcode_t OpBnn    = 7'b0001011;          // Custom-0 slot for BNN unit

    // ALU funct3 codes
    localparam funct3_t F3AddSub = 3'b000;              // Sub only on R-type with funct7b5
    localparam funct3_t F3Sll    = 3'b001;
    localparam funct3_t F3Slt    = 3'b010;
    localparam funct3_t F3Xor    = 3'b100;
    localparam funct3_t F3Srl    = 3'b101;
    localparam funct3_t F3Or     = 3'b110;
    localparam funct3_t F3And    = 3'b111;

    // Branch funct3 codes
    localparam funct3_t Beq = 3'b000;
    localparam funct3_t Bne = 3'b001;
    localparam funct3_t Blt = 3'b100;
    localparam funct3_t Bge = 3'b101;

    // BNN funct3 codes
    localparam funct3_t BnnRun       = 3'b000;          // Plain binarized run
    localparam funct3_t BnnSetSize   = 3'b001;          // Load matrix size
    localparam funct3_t BnnSetThresh = 3'b010;          // Load activation threshold
    localparam funct3_t BnnRunThresh = 3'b011;          // Run with thresholded activation

endpackage

// ==== verif/controlUnitTb.sv ====
`timescale 1ns/1ns

module controlUnitTb;
    import isaPkg::*;
    import ctrlPkg::*;

    localparam int ClkPeriod = 8;
    localparam int NumInstr  = 400;                     // Random instructions per run
    localparam int DrainCyc  = 4;                       // Bubbles to empty the pipe
    localparam int TimeoutNs = (NumInstr + DrainCyc + 12) * ClkPeriod * 2;
    localparam logic [31:0] Seed = 32'h108c_37d6;

    logic     clk        = 1'b0;
    logic     reset      = 1'b1;
    logic     Z          = 1'b0;
    logic     N          = 1'b0;
    logic     RegWE_W_W2 = 1'b0;
    regAddr_t A1_E       = '0;
    regAddr_t A2_E       = '0;
    regAddr_t A3_W       = '0;
    regAddr_t A4_W2      = '0;
    instr_t   InstrF     = '0;

    logic       RegWE_E_E, RegWE_W_W, OpBSrcE, en_threshold_E, ms_WE_E, at_WE_E;
    logic       StallF, StallD, FlushD, StallE, FlushE, FlushW, MemWriteW;
    fwdSel_t    fwdA_E, fwdB_E;
    pcSrc_t     PCSrcE;
    exPath_t    ExPathE;
    immFormat_t ImmFormatD;
    aluFunc_t   ALUFuncE;

    instr_t shD = '0;                                   // Shadow words in D, E and W
    instr_t shE = '0;
    instr_t shW = '0;

    int checkCount    = 0;
    int errorCount    = 0;
    int stallCount    = 0;
    int redirectCount = 0;

    controlUnit controlUnit_inst (.*);

    initial begin
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    function automatic aluFunc_t refAlu(input funct3_t f3, input logic sub);
        case (f3)
            3'b000:  return sub ? AluSub : AluAdd;
            3'b111:  return AluAnd;
            3'b110:  return AluOr;
            3'b100:  return AluXor;
            3'b010:  return AluSlt;
            3'b001:  return AluSll;
            3'b101:  return AluSrl;
            default: return AluAdd;                     // Unlisted code
        endcase
    endfunction

    // Expected Decode bundle for one instruction word
    function automatic decodeCtrl_t refDecode(input instr_t w);
        decodeCtrl_t c;
        funct3_t     f3;
        c  = '0;
        f3 = w[14:12];
        case (w[6:0])
            OpRType: begin
                c.regWeExec = 1'b1;
                c.aluFunc   = refAlu(f3, w[30]);
            end
            OpIType: begin
                c.regWeExec = 1'b1;
                c.opBSrc    = 1'b1;
                c.aluFunc   = refAlu(f3, 1'b0);
            end
            OpLoad: begin
                c.regWeMem = 1'b1;
                c.opBSrc   = 1'b1;
                c.exPath   = PathAddr;
            end
            OpStore: begin
                c.memWrite = 1'b1;
                c.opBSrc   = 1'b1;
            end
            OpBranch: begin
                c.branch  = 1'b1;
                c.aluFunc = AluSub;
                c.funct3  = f3;
            end
            OpJal: begin
                c.jump      = 1'b1;
                c.regWeExec = 1'b1;
                c.exPath    = PathLink;
            end
            OpBnn: begin
                if (f3 == BnnRun || f3 == BnnRunThresh) begin
                    c.regWeExec   = 1'b1;
                    c.exPath      = PathBnn;
                    c.enThreshold = (f3 == BnnRunThresh);
                end
                c.msWe = (f3 == BnnSetSize);
                c.atWe = (f3 == BnnSetThresh);
            end
            default: ;                                  // Bubble
        endcase
        return c;
    endfunction

    function automatic immFormat_t refImm(input instr_t w);
        if (w[6:0] == OpStore) return ImmS;
        if (w[6:0] == OpBranch) return ImmB;
        if (w[6:0] == OpJal) return ImmJ;
        return ImmI;
    endfunction

    // Branch outcome from the Z and N flags
    function automatic logic refCond(input instr_t w, input logic z, input logic n);
        if (w[6:0] != OpBranch) return 1'b0;
        case (w[14:12])
            Beq:     return z;
            Bne:     return !z;
            Blt:     return n;
            Bge:     return !n;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic refLoadUse(input logic wLoad, input regAddr_t a3,
                                        input regAddr_t a1, input regAddr_t a2);
        return wLoad && (a3 != 5'd0) && ((a3 == a1) || (a3 == a2));
    endfunction

    function automatic fwdSel_t refFwd(input regAddr_t src, input logic wWe, input regAddr_t a3,
                                       input logic w2We, input regAddr_t a4);
        if (src == 5'd0) return FwdRf;                  // Never bypass x0
        if (wWe && a3 == src) return FwdW;
        if (w2We && a4 == src) return FwdW2;
        return FwdRf;
    endfunction

    function automatic logic randBit();
        logic [31:0] r;
        r = $urandom;
        return r[0];
    endfunction

    function automatic regAddr_t randAddr();
        logic [31:0] r;
        r = $urandom;
        return {3'b000, r[1:0]};                        // Small range makes matches common
    endfunction

    // Random word of one class with class 7 left as a random opcode
    function automatic instr_t randInstr();
        logic [31:0] w;
        logic [31:0] pick;
        w    = $urandom;
        pick = $urandom % 8;
        case (pick)
            0:       w[6:0] = OpRType;
            1:       w[6:0] = OpIType;
            2:       w[6:0] = OpLoad;
            3:       w[6:0] = OpStore;
            4:       w[6:0] = OpBranch;
            5:       w[6:0] = OpJal;
            6:       w[6:0] = OpBnn;
            default: ;
        endcase
        return w;
    endfunction

    task automatic reportError(input string msg);
        errorCount++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    task automatic checkResetState();
        logic [11:0] gotC;
        logic [7:0]  gotH;
        gotC = {RegWE_E_E, OpBSrcE, en_threshold_E, ms_WE_E, at_WE_E, ExPathE, ALUFuncE,
                RegWE_W_W, MemWriteW};
        gotH = {StallF, StallD, StallE, FlushD, FlushE, FlushW, PCSrcE};
        checkCount += 2;
        if (gotC !== '0) reportError($sformatf("controls in reset got %h expected 0", gotC));
        if (gotH !== '0) reportError($sformatf("hazards in reset got %h expected 0", gotH));
    endtask

    task automatic checkOutputs();
        decodeCtrl_t ec;
        decodeCtrl_t wc;
        logic        lu;
        logic        rd;
        logic [9:0]  gotE, expE;
        logic [1:0]  gotW, expW;
        logic [7:0]  gotH, expH;
        logic [3:0]  gotF, expF;
        ec   = refDecode(shE);
        wc   = refDecode(shW);
        lu   = refLoadUse(wc.regWeMem, A3_W, A1_E, A2_E);
        rd   = (ec.jump || refCond(shE, Z, N)) && !lu;  // Held E never redirects
        gotE = {RegWE_E_E, OpBSrcE, en_threshold_E, ms_WE_E, at_WE_E, ExPathE, ALUFuncE};
        expE = {ec.regWeExec, ec.opBSrc, ec.enThreshold, ec.msWe, ec.atWe, ec.exPath, ec.aluFunc};
        gotW = {RegWE_W_W, MemWriteW};
        expW = {wc.regWeMem, wc.memWrite};
        gotH = {StallF, StallD, StallE, FlushD, FlushE, FlushW, PCSrcE};
        expH = {lu, lu, lu, rd, rd, lu, rd ? PcTarget : PcPlus4};
        gotF = {fwdA_E, fwdB_E};
        expF = {refFwd(A1_E, wc.regWeExec, A3_W, RegWE_W_W2, A4_W2),
                refFwd(A2_E, wc.regWeExec, A3_W, RegWE_W_W2, A4_W2)};
        checkCount += 5;
        if (gotE !== expE)
            reportError($sformatf("execute controls got %h expected %h", gotE, expE));
        if (gotW !== expW)
            reportError($sformatf("writeback controls got %h expected %h", gotW, expW));
        if (gotH !== expH)
            reportError($sformatf("stall/flush/pc got %h expected %h", gotH, expH));
        if (gotF !== expF)
            reportError($sformatf("forward selects got %h expected %h", gotF, expF));
        if (ImmFormatD !== refImm(shD))
            reportError($sformatf("ImmFormatD got %h expected %h", ImmFormatD, refImm(shD)));
        if (lu) stallCount++;
        if (rd) redirectCount++;
    endtask

    // Shadow pipeline steps with the DUT registers
    always @(posedge clk) begin : shadowPipe
        decodeCtrl_t ec;
        decodeCtrl_t wc;
        logic        lu;
        logic        rd;
        if (reset) begin
            shD = '0;
            shE = '0;
            shW = '0;
        end else begin
            ec  = refDecode(shE);
            wc  = refDecode(shW);
            lu  = refLoadUse(wc.regWeMem, A3_W, A1_E, A2_E);
            rd  = (ec.jump || refCond(shE, Z, N)) && !lu;
            shW = lu ? '0 : shE;                        // Bubble behind a held E
            if (rd) begin
                shE = '0;                               // Wrong-path slots killed
                shD = '0;
            end else if (!lu) begin
                shE = shD;
                shD = InstrF;
            end
        end
    end

    // Outputs are settled at the falling edge
    initial begin
        forever begin
            @(negedge clk);
            if (reset)
                checkResetState();
            else
                checkOutputs();
        end
    end

    initial begin
        void'($urandom(Seed));
        repeat (2) @(negedge clk);                      // Two reset edges
        reset <= 1'b0;
        for (int i = 0; i < NumInstr; i++) begin
            InstrF     <= randInstr();
            Z          <= randBit();
            N          <= randBit();
            RegWE_W_W2 <= randBit();
            A1_E       <= randAddr();
            A2_E       <= randAddr();
            A3_W       <= randAddr();
            A4_W2      <= randAddr();
            @(negedge clk);
        end
        repeat (DrainCyc) begin
            InstrF <= '0;                               // Bubbles flush the pipe
            @(negedge clk);
        end
        @(posedge clk);
        $display("Summary: %0d checks, %0d errors, %0d load-use stalls, %0d redirects",
                 checkCount, errorCount, stallCount, redirectCount);
        if (errorCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TimeoutNs);
        $display("Watchdog expired after %0d ns before the test ended", TimeoutNs);
        $display("Simulation failed");
        $finish;
    end

endmodule
